// File: dummy_ins.f
+incdir+src
src/dummy_ins_pkg.sv
src/xsecure_lfsr.sv
src/dummy_instr.sv
src/issue_mux.sv
src/dummy_ins_top.sv
dv/dummy_ins_assert.sv
dv/dummy_ins_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the dummy insertion testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dummy_ins_tb \
  -f dummy_ins.f -Mdir obj_dir > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vdummy_ins_tb > sim.log 2>&1 || echo "Simulator returned an error status"
grep -qx "Verification passed" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

// File: dv/dummy_ins_stimulus.txt
# name enable freq(hex) seed(hex) words ready_pct min_dummies
# min_dummies is the least number of accepted dummies the interval rule allows
disabled_full_ready  0 0 1234abcd 40  100 0
disabled_backpress   0 3 0badf00d 40  50  0
freq0_full_ready     1 0 6169a524 60  100 14
freq0_backpress      1 0 deadbeef 60  40  14
freq3_random_ready   1 3 13579bdf 80  70  4
freq15_max_interval  1 f 89abcdef 200 80  3
zero_seed_default    1 1 00000000 50  60  6
freq7_mixed          1 7 a5a5a5a5 100 90  3

// File: dv/dummy_ins_tb.sv
// Dummy insertion testbench
`include "dummy_ins_consts.svh"

module dummy_ins_tb;

  localparam int unsigned MAX_CYC = 4000;  // Cycle limit per test

  logic                  clk;
  logic                  rst_n;
  dummy_ins_pkg::fetch_t fetch_i;
  logic                  id_ready_i;
  logic                  allow_dummy_i;
  logic                  cfg_we_i;
  logic                  cfg_rnddummy_i;
  dummy_ins_pkg::freq_t  cfg_freq_i;
  logic                  seed_we_i;
  dummy_ins_pkg::lfsr_t  seed_i;
  dummy_ins_pkg::fetch_t id_o;
  logic                  id_is_dummy_o;
  logic                  fetch_hold_o;

  int unsigned val_errs;    // Wrong values seen
  int unsigned other_errs;  // Timeouts, bounds, file trouble
  logic [31:0] lfsr_m;      // Reference LFSR state
  logic        en_m;        // Reference enable
  logic [31:0] words[$];    // Real words not yet accepted

  dummy_ins_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Reference helpers
  //////////////////////////////

  // One right-shifting Galois step of the polynomial
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ `LFSR_TAPS) : (s >> 1);
  endfunction

  // ADD, MUL or AND into x0, or BLTU with zero offset
  function automatic bit dummy_legal(input logic [31:0] w);
    if (w[6:0] == `OPCODE_OP) begin
      return (w[11:7] == 5'd0) &&
             ((w[14:12] == `FUNCT3_ADD && w[31:25] inside {`FUNCT7_ADD, `FUNCT7_MUL}) ||
              (w[14:12] == `FUNCT3_AND && w[31:25] == `FUNCT7_ADD));
    end
    return (w[6:0] == `OPCODE_BRANCH) && (w[14:12] == `FUNCT3_BLTU) &&
           (w[31:25] == 7'd0) && (w[11:7] == 5'd0);  // All offset bits zero
  endfunction

  task automatic check_eq(input string test, input string what, input logic [32:0] exp,
                          input logic [32:0] act);
    assert (exp === act) else begin
      val_errs++;
      $display("error %s %s: expected %h actual %h", test, what, exp, act);
    end
  endtask

  //////////////////////////////
  // One test from the data file
  //////////////////////////////

  task automatic run_test(input string name, input bit en, input logic [3:0] freq,
                          input logic [31:0] seed, input int unsigned nwords,
                          input int unsigned ready_pct, input int unsigned min_d,
                          output bit timed_out);
    int unsigned cyc;
    int unsigned reals;
    int unsigned gap;      // Reals since the write or the last dummy
    int unsigned dummies;
    int unsigned bound;
    logic [31:0] head;
    bit          owed;     // Dummy offered and still waiting for decode
    bound = 4 * freq + 4;  // Threshold max is 4f+3, count must exceed it
    cyc = 0;
    reals = 0;
    gap = 0;
    dummies = 0;
    owed = 1'b0;
    @(negedge clk);
    fetch_i = '0;          // Write with fetch idle
    cfg_we_i = 1'b1;
    cfg_rnddummy_i = en;
    cfg_freq_i = freq;
    seed_we_i = 1'b1;
    seed_i = seed;
    lfsr_m = (seed == '0) ? `LFSR_DEFAULT_SEED : seed;  // Zero seed falls back
    en_m = en;
    words.delete();
    repeat (nwords) words.push_back($urandom);
    while (words.size() != 0 && cyc < MAX_CYC) begin
      @(negedge clk);
      cfg_we_i = 1'b0;
      seed_we_i = 1'b0;
      fetch_i.valid = (cyc != 0) && ($urandom_range(7) != 0);  // Counter restart cycle idle
      fetch_i.instr = words[0];
      id_ready_i = ($urandom_range(99) < ready_pct);
      #1;
      if (!en) check_eq(name, "dummy flag", 33'd0, id_is_dummy_o);
      // A stalled dummy keeps its slot until decode takes it
      if (owed && fetch_i.valid) begin
        assert (id_is_dummy_o) else begin
          other_errs++;
          $display("%s: offered dummy withdrawn before it was accepted", name);
        end
      end
      if (id_is_dummy_o) begin
        assert (dummy_legal(id_o.instr)) else begin
          other_errs++;
          $display("%s: dummy word %h is not one of the legal forms", name, id_o.instr);
        end
        check_eq(name, "rs1", lfsr_m[12:8], id_o.instr[19:15]);
        check_eq(name, "rs2", lfsr_m[20:16], id_o.instr[24:20]);
        check_eq(name, "fetch hold", 33'd1, fetch_hold_o);
        owed = !id_ready_i;
      end else begin
        check_eq(name, "pass-through", fetch_i, id_o);
      end
      if (id_o.valid && id_ready_i) begin
        if (id_is_dummy_o) begin
          // Count restarts at zero and must exceed the threshold first
          assert (gap != 0) else begin
            other_errs++;
            $display("%s: dummy accepted with no real instruction before it", name);
          end
          dummies++;
          gap = 0;
        end else begin
          head = words.pop_front();
          check_eq(name, "real word", head, id_o.instr);
          reals++;
          gap++;
          assert (!en || (gap <= bound && gap <= `MAX_DUMMY_INTERVAL)) else begin
            other_errs++;
            $display("%s: %0d real instructions without a dummy, limit %0d", name, gap, bound);
          end
        end
      end
      if (en_m) lfsr_m = lfsr_next(lfsr_m);  // Edge ahead steps the LFSR
      cyc++;
    end
    timed_out = (words.size() != 0);
    if (timed_out) begin
      other_errs++;
      $display("%s: timeout with %0d words left after %0d cycles", name, words.size(), cyc);
    end else begin
      check_eq(name, "real count", nwords, reals);
      assert (dummies >= min_d) else begin
        other_errs++;
        $display("%s: only %0d dummies issued, at least %0d needed", name, dummies, min_d);
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int          fd;
    int          code;
    string       line;
    string       name;
    int          en;
    int          freq;
    int          nwords;
    int          ready_pct;
    int          min_d;
    logic [31:0] seed;
    bit          tmo;
    void'($urandom(32'h6169_a524));
    val_errs = 0;
    other_errs = 0;
    tmo = 1'b0;
    rst_n = 1'b0;
    fetch_i = '0;
    id_ready_i = 1'b0;
    allow_dummy_i = 1'b1;
    cfg_we_i = 1'b0;
    cfg_rnddummy_i = 1'b0;
    cfg_freq_i = '0;
    seed_we_i = 1'b0;
    seed_i = '0;
    lfsr_m = `LFSR_DEFAULT_SEED;
    en_m = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fetch_i = {1'b1, 32'h0000_0013};  // Valid word right after reset
    id_ready_i = 1'b1;
    #1;
    check_eq("reset", "dummy flag", 33'd0, id_is_dummy_o);
    check_eq("reset", "fetch hold", 33'd0, fetch_hold_o);
    fd = $fopen("dv/dummy_ins_stimulus.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("cannot open the stimulus file");
    end else begin
      while (!$feof(fd) && !tmo) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %d %h %h %d %d %d", name, en, freq, seed, nwords,
                         ready_pct, min_d);
          if (code == 7) begin
            run_test(name, en != 0, freq[3:0], seed, nwords, ready_pct, min_d, tmo);
          end else begin
            other_errs++;
            $display("malformed stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : dummy_ins_tb

// File: dv/dummy_ins_assert.sv
// Dummy insertion bound checks
module dummy_ins_assert (
  input logic                  clk,
  input logic                  rst_n,
  input dummy_ins_pkg::fetch_t id_i,          // Slot toward decode
  input logic                  is_dummy_i,    // Slot tagged as dummy
  input logic                  fetch_hold_i,  // Fetch stalled
  input logic                  rnddummy_i     // Registered enable
);

  // Fetch only stalls behind a dummy
  a_hold_dummy : assert property (@(posedge clk) disable iff (!rst_n)
    fetch_hold_i |-> is_dummy_i)
    else $error("fetch hold raised without a dummy slot");

  // A dummy slot is always a valid slot
  a_dummy_valid : assert property (@(posedge clk) disable iff (!rst_n)
    is_dummy_i |-> id_i.valid)
    else $error("dummy slot presented with valid low");

  a_dummy_off : assert property (@(posedge clk) disable iff (!rst_n)
    !rnddummy_i |-> !is_dummy_i)  // Feature off means plain pass-through
    else $error("dummy issued while the feature is disabled");

endmodule : dummy_ins_assert

bind dummy_ins_top dummy_ins_assert u_dummy_ins_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .id_i         (id_o),
  .is_dummy_i   (id_is_dummy_o),
  .fetch_hold_i (fetch_hold_o),
  .rnddummy_i   (xsecure_ctrl.cpuctrl.rnddummy)
);

// File: src/dummy_ins_top.sv
// Dummy insertion top level
module dummy_ins_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dummy_ins_pkg::fetch_t fetch_i,         // Fetched instruction stream
  input  logic                  id_ready_i,      // Decode stage ready
  input  logic                  allow_dummy_i,   // Pipeline permits dummies
  input  logic                  cfg_we_i,        // cpuctrl write strobe
  input  logic                  cfg_rnddummy_i,
  input  dummy_ins_pkg::freq_t  cfg_freq_i,
  input  logic                  seed_we_i,       // LFSR seed write strobe
  input  dummy_ins_pkg::lfsr_t  seed_i,
  output dummy_ins_pkg::fetch_t id_o,            // Merged stream to decode
  output logic                  id_is_dummy_o,
  output logic                  fetch_hold_o
);

  dummy_ins_pkg::xsecure_ctrl_t xsecure_ctrl;  // Config, random bits, restart
  dummy_ins_pkg::instr_t        dummy_instr;   // Current dummy encoding
  logic                         dummy_insert;
  logic                         instr_issued;  // Back from the mux to the counter

  // Random source and config
  xsecure_lfsr u_xsecure_lfsr (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_we_i       (cfg_we_i),
    .cfg_rnddummy_i (cfg_rnddummy_i),
    .cfg_freq_i     (cfg_freq_i),
    .seed_we_i      (seed_we_i),
    .seed_i         (seed_i),
    .xsecure_o      (xsecure_ctrl)
  );

  // Interval counter and encoder
  dummy_instr u_dummy_instr (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_issued_i (instr_issued),
    .allow_dummy_i  (allow_dummy_i),
    .xsecure_ctrl_i (xsecure_ctrl),
    .dummy_insert_o (dummy_insert),
    .dummy_instr_o  (dummy_instr)
  );

  // Merge into the decode stream
  issue_mux u_issue_mux (
    .fetch_i        (fetch_i),
    .id_ready_i     (id_ready_i),
    .dummy_insert_i (dummy_insert),
    .dummy_instr_i  (dummy_instr),
    .id_o           (id_o),
    .id_is_dummy_o  (id_is_dummy_o),
    .fetch_hold_o   (fetch_hold_o),
    .instr_issued_o (instr_issued)
  );

endmodule : dummy_ins_top

// File: src/issue_mux.sv
// Issue multiplexer
module issue_mux (
  input  dummy_ins_pkg::fetch_t fetch_i,         // Word from fetch
  input  logic                  id_ready_i,      // Decode can accept
  input  logic                  dummy_insert_i,  // Generator wants a slot
  input  dummy_ins_pkg::instr_t dummy_instr_i,   // Dummy encoding
  output dummy_ins_pkg::fetch_t id_o,            // Slot toward decode
  output logic                  id_is_dummy_o,   // Slot carries a dummy
  output logic                  fetch_hold_o,    // Fetch keeps its word
  output logic                  instr_issued_o   // Slot accepted this cycle
);

  logic                  take_slot;  // Dummy wins this cycle
  dummy_ins_pkg::fetch_t dummy_slot;
  dummy_ins_pkg::fetch_t mux_slot;

  //////////////////////////////
  // Slot arbitration
  //////////////////////////////

  // A dummy only borrows a slot that a real word would have used,
  // so every dummy sits directly in front of a real instruction
  assign take_slot = dummy_insert_i && fetch_i.valid;

  assign dummy_slot.valid = 1'b1;
  assign dummy_slot.instr = dummy_instr_i;

  always_comb begin
    if (take_slot) begin
      mux_slot = dummy_slot;  // Real word waits behind the dummy
    end else begin
      mux_slot = fetch_i;     // Straight pass of the fetched slot
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign id_o          = mux_slot;
  assign id_is_dummy_o = take_slot;  // Tag for decode and tracing

  // Fetch must not advance past the displaced word
  assign fetch_hold_o  = take_slot;

  // Feeds the interval counter, covers real and dummy slots
  assign instr_issued_o = mux_slot.valid && id_ready_i;

endmodule : issue_mux

// File: src/dummy_instr.sv
// Dummy instruction generator
`include "dummy_ins_consts.svh"

module dummy_instr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         instr_issued_i,  // Slot accepted by decode
  input  logic                         allow_dummy_i,   // Pipeline permits dummies
  input  dummy_ins_pkg::xsecure_ctrl_t xsecure_ctrl_i,
  output logic                         dummy_insert_o,  // Offer a dummy this cycle
  output dummy_ins_pkg::instr_t        dummy_instr_o
);

  localparam int unsigned CNT_MAX_I = `MAX_DUMMY_INTERVAL;  // Saturation point of the counter

  logic [`CNT_W-1:0] cnt_q;      // Real instructions since last dummy
  logic [`CNT_W-1:0] cnt_next;
  logic              cnt_rst;
  logic              pend_q;     // Dummy offered but not yet taken
  logic              dummy_en;

  logic [1:0]        lfsr_sel;   // Instruction form
  logic [4:0]        lfsr_rs1;
  logic [4:0]        lfsr_rs2;
  logic [5:0]        lfsr_cnt;   // Masked random threshold

  logic [6:0]        opcode;
  logic [6:0]        funct7;
  logic [2:0]        funct3;

  //////////////////////////////
  // Random fields
  //////////////////////////////

  assign lfsr_sel = xsecure_ctrl_i.lfsr0[1:0];
  assign lfsr_rs1 = xsecure_ctrl_i.lfsr0[12:8];
  assign lfsr_rs2 = xsecure_ctrl_i.lfsr0[20:16];
  // Frequency code limits the upper threshold bits
  assign lfsr_cnt = xsecure_ctrl_i.lfsr0[29:24] &
                    {xsecure_ctrl_i.cpuctrl.rnddummyfreq, 2'b11};

  //////////////////////////////
  // Interval counter
  //////////////////////////////

  assign dummy_en = allow_dummy_i && xsecure_ctrl_i.cpuctrl.rnddummy;

  // Pending flag keeps the slot a dummy while the LFSR moves under stall
  assign dummy_insert_o = dummy_en && ((cnt_q > {1'b0, lfsr_cnt}) || pend_q);

  assign cnt_rst = !dummy_en                          ||  // Feature off
                   (dummy_insert_o && instr_issued_i) ||  // Own dummy taken
                   xsecure_ctrl_i.cntrst;                 // Config or seed written

  always_comb begin
    if (cnt_rst) begin
      cnt_next = '0;
    end else if (instr_issued_i && (cnt_q != CNT_MAX_I[`CNT_W-1:0])) begin
      cnt_next = cnt_q + 1'b1;      // Count real issues only
    end else begin
      cnt_next = cnt_q;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      pend_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_next;
      pend_q <= dummy_insert_o && !cnt_rst;  // Held until accepted or cleared
    end
  end

  //////////////////////////////
  // Encoder
  //////////////////////////////

  always_comb begin
    case (lfsr_sel)
      2'b00: begin  // ADD
        opcode = `OPCODE_OP;
        funct3 = `FUNCT3_ADD;
        funct7 = `FUNCT7_ADD;
      end
      2'b01: begin  // MUL
        opcode = `OPCODE_OP;
        funct3 = `FUNCT3_ADD;
        funct7 = `FUNCT7_MUL;
      end
      2'b10: begin  // AND
        opcode = `OPCODE_OP;
        funct3 = `FUNCT3_AND;
        funct7 = `FUNCT7_ADD;
      end
      default: begin  // BLTU
        opcode = `OPCODE_BRANCH;
        funct3 = `FUNCT3_BLTU;
        funct7 = 7'h0;  // Offset bits 12 and 10:5 stay zero
      end
    endcase
  end

  // Branch target equals the real instruction's PC
  assign dummy_instr_o[31:25] = funct7;
  assign dummy_instr_o[24:20] = lfsr_rs2;
  assign dummy_instr_o[19:15] = lfsr_rs1;
  assign dummy_instr_o[14:12] = funct3;
  assign dummy_instr_o[11:7]  = 5'h0;    // Result into x0 or zero lower offset
  assign dummy_instr_o[6:0]   = opcode;

endmodule : dummy_instr

// File: src/xsecure_lfsr.sv
// Security config and LFSR
`include "dummy_ins_consts.svh"

module xsecure_lfsr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cfg_we_i,        // Config write strobe
  input  logic                         cfg_rnddummy_i,  // New enable value
  input  dummy_ins_pkg::freq_t         cfg_freq_i,      // New frequency code
  input  logic                         seed_we_i,       // Seed write strobe
  input  dummy_ins_pkg::lfsr_t         seed_i,          // New seed value
  output dummy_ins_pkg::xsecure_ctrl_t xsecure_o
);

  dummy_ins_pkg::cpuctrl_t cpuctrl_q;   // Config register
  dummy_ins_pkg::lfsr_t    lfsr_q;      // LFSR state
  dummy_ins_pkg::lfsr_t    lfsr_step;   // State after one shift
  dummy_ins_pkg::lfsr_t    seed_safe;   // Seed with zero filtered out
  logic                    cntrst_q;    // Counter reset pulse

  //////////////////////////////
  // Next state
  //////////////////////////////

  // Shift right, fold the taps back in when a one drops out
  assign lfsr_step = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? `LFSR_TAPS : 32'h0);

  // An all-zero state would lock up the LFSR
  assign seed_safe = (seed_i == '0) ? `LFSR_DEFAULT_SEED : seed_i;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cpuctrl_q <= '0;                  // Dummies off after reset
      lfsr_q    <= `LFSR_DEFAULT_SEED;
      cntrst_q  <= 1'b0;
    end else begin
      if (cfg_we_i) begin
        cpuctrl_q.rnddummy     <= cfg_rnddummy_i;
        cpuctrl_q.rnddummyfreq <= cfg_freq_i;
      end
      // Seed load wins over stepping
      if (seed_we_i) begin
        lfsr_q <= seed_safe;
      end else if (cpuctrl_q.rnddummy) begin
        lfsr_q <= lfsr_step;            // Only runs while the feature is on
      end
      cntrst_q <= cfg_we_i || seed_we_i;  // Restart counting after any write
    end
  end

  assign xsecure_o.lfsr0   = lfsr_q;
  assign xsecure_o.cpuctrl = cpuctrl_q;
  assign xsecure_o.cntrst  = cntrst_q;

endmodule : xsecure_lfsr

// File: src/dummy_ins_pkg.sv
// Dummy insertion types
package dummy_ins_pkg;

  //////////////////////////////
  // Plain vectors
  //////////////////////////////

  typedef logic [31:0] instr_t;  // Raw 32-bit instruction word
  typedef logic [31:0] lfsr_t;   // LFSR state
  typedef logic [3:0]  freq_t;   // Dummy frequency code

  //////////////////////////////
  // Control structs
  //////////////////////////////

  // Subset of the cpuctrl CSR that drives the dummy unit
  typedef struct packed {
    logic  rnddummy;      // Feature enable
    freq_t rnddummyfreq;  // Upper threshold mask bits
  } cpuctrl_t;

  // Everything the dummy generator needs from the security block
  typedef struct packed {
    lfsr_t    lfsr0;    // Random bits, one step per enabled cycle
    cpuctrl_t cpuctrl;  // Registered config
    logic     cntrst;   // One-cycle pulse after a config or seed write
  } xsecure_ctrl_t;

  //////////////////////////////
  // Instruction stream
  //////////////////////////////

  // One slot of the fetch or issue stream
  typedef struct packed {
    logic   valid;  // Word present this cycle
    instr_t instr;  // Instruction payload
  } fetch_t;

endpackage : dummy_ins_pkg

// File: src/dummy_ins_consts.svh
// Dummy insertion constants
`ifndef DUMMY_INS_CONSTS_SVH
`define DUMMY_INS_CONSTS_SVH

// Largest number of real instructions between two dummies
`define MAX_DUMMY_INTERVAL 64
`define CNT_W              7              // Holds 0 to MAX_DUMMY_INTERVAL

// RV32 major opcodes
`define OPCODE_OP          7'b011_0011    // Register-register ALU ops
`define OPCODE_BRANCH      7'b110_0011    // Conditional branches

// Function fields of the dummy forms
`define FUNCT3_ADD         3'b000         // Also used by MUL
`define FUNCT3_AND         3'b111
`define FUNCT3_BLTU        3'b110
`define FUNCT7_ADD         7'b000_0000    // Also used by AND
`define FUNCT7_MUL         7'b000_0001    // M extension

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, right shifting
`define LFSR_TAPS          32'h8020_0003
`define LFSR_DEFAULT_SEED  32'h2c9f_7a51  // Must never be zero

`endif
